//--- source/blimp_defs.svh
/*
 * Build-wide constants for the blimp core.
 * Include this file wherever the reset PC, data width or opcode values are needed.
 */

`ifndef BLIMP_DEFS_SVH
`define BLIMP_DEFS_SVH

// ---------------------------------------------------------------------
// Core geometry
// ---------------------------------------------------------------------

// First fetch address out of reset
`define BLIMP_RESET_PC 32'h0000_0000

// Register and data bus width
`define BLIMP_XLEN 32

// ---------------------------------------------------------------------
// RV32 major opcodes (inst[6:0])
// ---------------------------------------------------------------------

`define BLIMP_OP_REG   7'b0110011
`define BLIMP_OP_IMM   7'b0010011
`define BLIMP_OP_LOAD  7'b0000011
`define BLIMP_OP_STORE 7'b0100011

`endif

//--- source/blimp_pkg.sv
/*
 * Shared types of the blimp core.
 * Reach them by scoped names, e.g. blimp_pkg::word_t.
 */

`include "blimp_defs.svh"

package blimp_pkg;

  // ---------------------------------------------------------------------
  // Vector types
  // ---------------------------------------------------------------------

  // Data or instruction word
  typedef logic [`BLIMP_XLEN-1:0] word_t;

  // Byte address
  typedef logic [31:0] addr_t;

  // Architectural register index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // ---------------------------------------------------------------------
  // Enums
  // ---------------------------------------------------------------------

  // ALU operation, pass forwards operand b
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_PASS
  } alu_op_t;

  // What the memory/writeback stage does with an instruction
  typedef enum logic [1:0] {
    XFER_ALU,
    XFER_LOAD,
    XFER_STORE,
    XFER_NOP
  } xfer_kind_t;

  // APB requester phase
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_t;

endpackage

//--- source/blimp_ifs.sv
/*
 * Internal handshake buses of the blimp core.
 * inst_if links fetch to exec, xfer_if links exec to mem/writeback.
 */

// Fetched instruction, valid/ready handshake
interface inst_if;
  logic                val;
  logic                rdy;
  blimp_pkg::addr_t    pc;
  blimp_pkg::word_t    inst;

  modport fetch (output val, pc, inst, input rdy);
  modport exec  (input val, pc, inst, output rdy);
endinterface

// Decoded instruction forward, writeback group backward
interface xfer_if;
  logic                   val;
  logic                   rdy;
  blimp_pkg::xfer_kind_t  kind;
  blimp_pkg::addr_t       pc;
  blimp_pkg::reg_idx_t    rd;
  blimp_pkg::addr_t       addr;
  blimp_pkg::word_t       wdata;
  blimp_pkg::word_t       result;

  // Register file write port
  logic                   wb_en;
  blimp_pkg::reg_idx_t    wb_idx;
  blimp_pkg::word_t       wb_data;

  modport exec (
    output val, kind, pc, rd, addr, wdata, result,
    input  rdy, wb_en, wb_idx, wb_data
  );
  modport mem (
    input  val, kind, pc, rd, addr, wdata, result,
    output rdy, wb_en, wb_idx, wb_data
  );
endinterface

//--- source/fetch_unit.sv
/*
 * Instruction fetch over an APB requester port.
 * Fetches sequentially from the reset PC into a one-entry buffer
 * and offers the buffered instruction on inst_if.
 */

`include "blimp_defs.svh"

module fetch_unit (
  input  logic                clk,
  input  logic                rst_n,

  // Instruction memory APB
  output logic                imem_psel,
  output logic                imem_penable,
  output blimp_pkg::addr_t    imem_paddr,
  input  logic                imem_pready,
  input  blimp_pkg::word_t    imem_prdata,

  inst_if.fetch               inst_bus
);

  blimp_pkg::apb_state_t state;
  blimp_pkg::addr_t      pc_q;

  // One-entry instruction buffer
  logic                  buf_val;
  blimp_pkg::addr_t      buf_pc;
  blimp_pkg::word_t      buf_inst;

  logic take;
  logic done;

  assign take = inst_bus.val & inst_bus.rdy;
  assign done = (state == blimp_pkg::APB_ACCESS) & imem_pready;

  // ---------------------------------------------------------------------
  // APB sequencing
  // ---------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= blimp_pkg::APB_IDLE;
      pc_q    <= `BLIMP_RESET_PC;
      buf_val <= 1'b0;
    end else begin
      case (state)
        // Start only when the buffer is, or is about to be, empty
        blimp_pkg::APB_IDLE:  if (!buf_val || take) state <= blimp_pkg::APB_SETUP;
        blimp_pkg::APB_SETUP: state <= blimp_pkg::APB_ACCESS;
        // Buffer is full after this, so back to idle
        blimp_pkg::APB_ACCESS: if (imem_pready) state <= blimp_pkg::APB_IDLE;
        default: state <= blimp_pkg::APB_IDLE;
      endcase

      if (done) begin
        pc_q    <= pc_q + 32'd4;
        buf_val <= 1'b1;
      end else if (take) begin
        buf_val <= 1'b0;
      end
    end
  end

  // Buffer payload
  always_ff @(posedge clk) begin
    if (done) begin
      buf_inst <= imem_prdata;
      buf_pc   <= pc_q;
    end
  end

  assign imem_psel    = (state != blimp_pkg::APB_IDLE);
  assign imem_penable = (state == blimp_pkg::APB_ACCESS);
  assign imem_paddr   = pc_q;

  assign inst_bus.val  = buf_val;
  assign inst_bus.pc   = buf_pc;
  assign inst_bus.inst = buf_inst;

  // Address held across wait states
  assert property (@(posedge clk) disable iff (!rst_n)
    imem_penable && !imem_pready |=> $stable(imem_paddr));

endmodule

//--- source/exec_unit.sv
/*
 * Decode and execute stage with the register file.
 * Takes one instruction from inst_if, registers it decoded, and hands it
 * to mem/writeback on xfer_if. The write port is the xfer_if writeback group.
 */

`include "blimp_defs.svh"

module exec_unit (
  input  logic   clk,
  input  logic   rst_n,
  inst_if.exec   inst_bus,
  xfer_if.exec   xfer_bus
);

  // ---------------------------------------------------------------------
  // Field extraction
  // ---------------------------------------------------------------------

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  blimp_pkg::reg_idx_t   rd;
  blimp_pkg::reg_idx_t   rs1;
  blimp_pkg::reg_idx_t   rs2;
  blimp_pkg::word_t      imm_i;
  blimp_pkg::word_t      imm_s;

  assign opcode = inst_bus.inst[6:0];
  assign rd     = inst_bus.inst[11:7];
  assign funct3 = inst_bus.inst[14:12];
  assign rs1    = inst_bus.inst[19:15];
  assign rs2    = inst_bus.inst[24:20];
  assign funct7 = inst_bus.inst[31:25];
  // Sign-extended immediates
  assign imm_i  = {{20{inst_bus.inst[31]}}, inst_bus.inst[31:20]};
  assign imm_s  = {{20{inst_bus.inst[31]}}, inst_bus.inst[31:25], inst_bus.inst[11:7]};

  // ---------------------------------------------------------------------
  // Register file
  // ---------------------------------------------------------------------

  blimp_pkg::word_t regs [32];
  blimp_pkg::word_t rs1_val;
  blimp_pkg::word_t rs2_val;

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (xfer_bus.wb_en && xfer_bus.wb_idx != '0) begin
      regs[xfer_bus.wb_idx] <= xfer_bus.wb_data;
    end
  end

  // ---------------------------------------------------------------------
  // Decode and ALU
  // ---------------------------------------------------------------------

  blimp_pkg::xfer_kind_t kind_d;
  blimp_pkg::alu_op_t    alu_op;
  blimp_pkg::word_t      op_b;
  blimp_pkg::word_t      alu_out;

  always_comb begin
    // Unsupported encodings retire as a no-op
    kind_d = blimp_pkg::XFER_NOP;
    alu_op = blimp_pkg::ALU_PASS;
    op_b   = '0;
    case (opcode)
      `BLIMP_OP_REG: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          kind_d = blimp_pkg::XFER_ALU;
          alu_op = blimp_pkg::ALU_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          kind_d = blimp_pkg::XFER_ALU;
          alu_op = blimp_pkg::ALU_SUB;
        end else if (funct3 == 3'b111 && funct7 == 7'b0000000) begin
          kind_d = blimp_pkg::XFER_ALU;
          alu_op = blimp_pkg::ALU_AND;
        end
        op_b = rs2_val;
      end
      `BLIMP_OP_IMM: if (funct3 == 3'b000) begin
        kind_d = blimp_pkg::XFER_ALU;
        alu_op = blimp_pkg::ALU_ADD;
        op_b   = imm_i;
      end
      // LW and SW only, the ALU forms the effective address
      `BLIMP_OP_LOAD: if (funct3 == 3'b010) begin
        kind_d = blimp_pkg::XFER_LOAD;
        alu_op = blimp_pkg::ALU_ADD;
        op_b   = imm_i;
      end
      `BLIMP_OP_STORE: if (funct3 == 3'b010) begin
        kind_d = blimp_pkg::XFER_STORE;
        alu_op = blimp_pkg::ALU_ADD;
        op_b   = imm_s;
      end
      default: kind_d = blimp_pkg::XFER_NOP;
    endcase
  end

  always_comb begin
    case (alu_op)
      blimp_pkg::ALU_ADD: alu_out = rs1_val + op_b;
      blimp_pkg::ALU_SUB: alu_out = rs1_val - op_b;
      blimp_pkg::ALU_AND: alu_out = rs1_val & op_b;
      default:            alu_out = op_b;
    endcase
  end

  // ---------------------------------------------------------------------
  // Decoded instruction hold
  // ---------------------------------------------------------------------

  logic take;
  logic hold_val;

  // Wait for mem/writeback to drain so operands are current
  assign inst_bus.rdy = !hold_val && xfer_bus.rdy;
  assign take         = inst_bus.val && inst_bus.rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_val <= 1'b0;
    end else if (take) begin
      hold_val <= 1'b1;
    end else if (xfer_bus.rdy) begin
      hold_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      xfer_bus.kind   <= kind_d;
      xfer_bus.pc     <= inst_bus.pc;
      xfer_bus.rd     <= rd;
      xfer_bus.addr   <= alu_out;
      xfer_bus.wdata  <= rs2_val;
      xfer_bus.result <= alu_out;
    end
  end

  assign xfer_bus.val = hold_val;

  // Writeback side must never target x0
  assert property (@(posedge clk) disable iff (!rst_n)
    xfer_bus.wb_en |-> xfer_bus.wb_idx != '0);

endmodule

//--- source/mem_wb_unit.sv
/*
 * Memory access and writeback stage.
 * Runs loads and stores on the data APB port, writes the register file
 * and reports every retired instruction on the trace port.
 */

module mem_wb_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  xfer_if.mem                   xfer_bus,

  // Data memory APB
  output logic                  dmem_psel,
  output logic                  dmem_penable,
  output logic                  dmem_pwrite,
  output blimp_pkg::addr_t      dmem_paddr,
  output blimp_pkg::word_t      dmem_pwdata,
  input  logic                  dmem_pready,
  input  blimp_pkg::word_t      dmem_prdata,

  // Retire trace
  output logic                  trace_val,
  output blimp_pkg::addr_t      trace_pc,
  output blimp_pkg::reg_idx_t   trace_waddr,
  output blimp_pkg::word_t      trace_wdata,
  output logic                  trace_wen
);

  blimp_pkg::apb_state_t state;
  logic                  busy;
  logic                  ret_val;
  logic                  pwrite_q;
  logic                  take;
  logic                  is_mem;
  logic                  is_wr;

  // Held instruction
  blimp_pkg::xfer_kind_t kind_q;
  blimp_pkg::addr_t      pc_q;
  blimp_pkg::reg_idx_t   rd_q;
  blimp_pkg::addr_t      addr_q;
  blimp_pkg::word_t      wdata_q;
  blimp_pkg::word_t      result_q;
  blimp_pkg::word_t      load_q;

  assign xfer_bus.rdy = !busy;
  assign take   = xfer_bus.val && !busy;
  assign is_mem = (xfer_bus.kind == blimp_pkg::XFER_LOAD) ||
                  (xfer_bus.kind == blimp_pkg::XFER_STORE);

  // ---------------------------------------------------------------------
  // Control
  // ---------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= blimp_pkg::APB_IDLE;
      busy     <= 1'b0;
      ret_val  <= 1'b0;
      pwrite_q <= 1'b0;
    end else begin
      ret_val <= 1'b0;
      case (state)
        blimp_pkg::APB_IDLE: if (take) begin
          busy <= 1'b1;
          if (is_mem) begin
            state    <= blimp_pkg::APB_SETUP;
            pwrite_q <= (xfer_bus.kind == blimp_pkg::XFER_STORE);
          end else begin
            // ALU and nop retire next cycle
            ret_val <= 1'b1;
          end
        end
        blimp_pkg::APB_SETUP: state <= blimp_pkg::APB_ACCESS;
        blimp_pkg::APB_ACCESS: if (dmem_pready) begin
          state    <= blimp_pkg::APB_IDLE;
          pwrite_q <= 1'b0;
          ret_val  <= 1'b1;
        end
        default: state <= blimp_pkg::APB_IDLE;
      endcase
      if (ret_val) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      kind_q   <= xfer_bus.kind;
      pc_q     <= xfer_bus.pc;
      rd_q     <= xfer_bus.rd;
      addr_q   <= xfer_bus.addr;
      wdata_q  <= xfer_bus.wdata;
      result_q <= xfer_bus.result;
    end
    if (state == blimp_pkg::APB_ACCESS && dmem_pready) load_q <= dmem_prdata;
  end

  assign dmem_psel    = (state != blimp_pkg::APB_IDLE);
  assign dmem_penable = (state == blimp_pkg::APB_ACCESS);
  assign dmem_pwrite  = pwrite_q;
  assign dmem_paddr   = addr_q;
  assign dmem_pwdata  = wdata_q;

  // ---------------------------------------------------------------------
  // Writeback and trace
  // ---------------------------------------------------------------------

  assign is_wr = (kind_q == blimp_pkg::XFER_ALU) || (kind_q == blimp_pkg::XFER_LOAD);

  assign xfer_bus.wb_en   = ret_val && is_wr && (rd_q != '0);
  assign xfer_bus.wb_idx  = rd_q;
  assign xfer_bus.wb_data = (kind_q == blimp_pkg::XFER_LOAD) ? load_q : result_q;

  assign trace_val   = ret_val;
  assign trace_pc    = pc_q;
  assign trace_waddr = is_wr ? rd_q : '0;
  // Stores and nops report zero
  assign trace_wdata = is_wr ? xfer_bus.wb_data : '0;
  assign trace_wen   = xfer_bus.wb_en;

  // Write strobe belongs to a store in flight
  assert property (@(posedge clk) disable iff (!rst_n)
    dmem_pwrite |-> dmem_psel && kind_q == blimp_pkg::XFER_STORE);

endmodule

//--- source/blimp_core.sv
/*
 * Top level of the blimp RV32 subset core.
 * Two APB requester ports (instruction, data) and a retire trace port.
 */

module blimp_core (
  input  logic                  clk,
  input  logic                  rst_n,

  // Instruction APB, read only
  output logic                  imem_psel,
  output logic                  imem_penable,
  output blimp_pkg::addr_t      imem_paddr,
  input  logic                  imem_pready,
  input  blimp_pkg::word_t      imem_prdata,

  // Data APB
  output logic                  dmem_psel,
  output logic                  dmem_penable,
  output logic                  dmem_pwrite,
  output blimp_pkg::addr_t      dmem_paddr,
  output blimp_pkg::word_t      dmem_pwdata,
  input  logic                  dmem_pready,
  input  blimp_pkg::word_t      dmem_prdata,

  // Retire trace
  output logic                  trace_val,
  output blimp_pkg::addr_t      trace_pc,
  output blimp_pkg::reg_idx_t   trace_waddr,
  output blimp_pkg::word_t      trace_wdata,
  output logic                  trace_wen
);

  inst_if inst_bus ();
  xfer_if xfer_bus ();

  fetch_unit fetch0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .imem_psel    (imem_psel),
    .imem_penable (imem_penable),
    .imem_paddr   (imem_paddr),
    .imem_pready  (imem_pready),
    .imem_prdata  (imem_prdata),
    .inst_bus     (inst_bus.fetch)
  );

  exec_unit exec0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .inst_bus (inst_bus.exec),
    .xfer_bus (xfer_bus.exec)
  );

  mem_wb_unit mem_wb0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .xfer_bus     (xfer_bus.mem),
    .dmem_psel    (dmem_psel),
    .dmem_penable (dmem_penable),
    .dmem_pwrite  (dmem_pwrite),
    .dmem_paddr   (dmem_paddr),
    .dmem_pwdata  (dmem_pwdata),
    .dmem_pready  (dmem_pready),
    .dmem_prdata  (dmem_prdata),
    .trace_val    (trace_val),
    .trace_pc     (trace_pc),
    .trace_waddr  (trace_waddr),
    .trace_wdata  (trace_wdata),
    .trace_wen    (trace_wen)
  );

endmodule

//--- testbench/tb_mem_model.sv
/*
 * APB completer model serving the instruction and data ports of the core.
 * The testbench fills the word arrays and supplies a wait count per port.
 */

module tb_mem_model (
  input  logic               clk,
  input  logic               rst_n,

  // Instruction port, read only
  input  logic               imem_psel,
  input  logic               imem_penable,
  input  blimp_pkg::addr_t   imem_paddr,
  output logic               imem_pready,
  output blimp_pkg::word_t   imem_prdata,
  input  logic [1:0]         imem_wait,

  // Data port
  input  logic               dmem_psel,
  input  logic               dmem_penable,
  input  logic               dmem_pwrite,
  input  blimp_pkg::addr_t   dmem_paddr,
  input  blimp_pkg::word_t   dmem_pwdata,
  output logic               dmem_pready,
  output blimp_pkg::word_t   dmem_prdata,
  input  logic [1:0]         dmem_wait
);

  // Backing store, 1 KiB of code and 2 KiB of data
  blimp_pkg::word_t imem_words [256];
  blimp_pkg::word_t dmem_words [512];

  // Wait states left in the current access
  logic [1:0] imem_left;
  logic [1:0] dmem_left;

  assign imem_pready = imem_psel && imem_penable && (imem_left == 2'd0);
  assign imem_prdata = imem_words[imem_paddr[9:2]];
  assign dmem_pready = dmem_psel && dmem_penable && (dmem_left == 2'd0);
  assign dmem_prdata = dmem_words[dmem_paddr[10:2]];

  // ---------------------------------------------------------------------
  // Wait state counters
  // ---------------------------------------------------------------------

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      imem_left <= 2'd0;
      dmem_left <= 2'd0;
    end else begin
      // Setup cycle latches the count for the access
      if (imem_psel && !imem_penable) begin
        imem_left <= imem_wait;
      end else if (imem_penable && !imem_pready) begin
        imem_left <= imem_left - 2'd1;
      end
      if (dmem_psel && !dmem_penable) begin
        dmem_left <= dmem_wait;
      end else if (dmem_penable && !dmem_pready) begin
        dmem_left <= dmem_left - 2'd1;
      end
    end
  end

  // Store lands on the last access cycle
  always @(posedge clk) begin
    if (dmem_psel && dmem_penable && dmem_pready && dmem_pwrite) begin
      dmem_words[dmem_paddr[10:2]] <= dmem_pwdata;
    end
  end

endmodule

//--- testbench/tb_blimp.sv
/*
 * Testbench for the blimp core.
 * Runs a random program from a fixed seed, checks each retire against an
 * ISA model and compares the data memory with the model at the end.
 */

`include "blimp_defs.svh"

module tb_blimp;

  localparam int NUM_INSTS      = 200;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * 12 + 100;
  localparam int IMEM_WORDS     = 256;
  localparam int DMEM_WORDS     = 512;

  // Instruction classes of the random program
  localparam int OP_ADD  = 0;
  localparam int OP_SUB  = 1;
  localparam int OP_AND  = 2;
  localparam int OP_ADDI = 3;
  localparam int OP_LW   = 4;
  localparam int OP_SW   = 5;

  logic                clk;
  logic                rst_n;
  logic                imem_psel, imem_penable, imem_pready;
  blimp_pkg::addr_t    imem_paddr;
  blimp_pkg::word_t    imem_prdata;
  logic                dmem_psel, dmem_penable, dmem_pwrite, dmem_pready;
  blimp_pkg::addr_t    dmem_paddr;
  blimp_pkg::word_t    dmem_pwdata, dmem_prdata;
  logic                trace_val, trace_wen;
  blimp_pkg::addr_t    trace_pc;
  blimp_pkg::reg_idx_t trace_waddr;
  blimp_pkg::word_t    trace_wdata;
  logic [1:0]          imem_wait, dmem_wait;

  // Program as generated, and the ISA model state
  int                  prog_op  [NUM_INSTS];
  int                  prog_rd  [NUM_INSTS];
  int                  prog_rs1 [NUM_INSTS];
  int                  prog_rs2 [NUM_INSTS];
  logic [31:0]         prog_imm [NUM_INSTS];
  logic [31:0]         model_regs [32];
  logic [31:0]         model_data [DMEM_WORDS];
  logic [31:0]         rand_state;
  int                  retired;
  int                  cycle_count;

  blimp_core dut0 (.*);

  tb_mem_model mem0 (.*);

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Upper LCG bits, the low ones cycle too fast
  function automatic int rand_below(int n);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:16]) % n;
  endfunction

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] encode_inst(int i);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = 5'(prog_rd[i]);
    rs1 = 5'(prog_rs1[i]);
    rs2 = 5'(prog_rs2[i]);
    imm = prog_imm[i][11:0];
    case (prog_op[i])
      OP_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, `BLIMP_OP_REG};
      OP_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, `BLIMP_OP_REG};
      OP_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, `BLIMP_OP_REG};
      OP_ADDI: return {imm, rs1, 3'b000, rd, `BLIMP_OP_IMM};
      OP_LW:   return {imm, rs1, 3'b010, rd, `BLIMP_OP_LOAD};
      default: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `BLIMP_OP_STORE};
    endcase
  endfunction

  // Random program at address 0, padded with ADDI x0, x0, 0
  task automatic build_program();
    logic [31:0] r;
    for (int i = 0; i < NUM_INSTS; i++) begin
      prog_op[i]  = rand_below(6);
      prog_rd[i]  = rand_below(32);
      prog_rs1[i] = rand_below(32);
      prog_rs2[i] = rand_below(32);
      r = lcg_next();
      prog_imm[i] = {{20{r[27]}}, r[27:16]};
      // Memory ops use x0 as base, word offsets 0x400..0x7fc
      if (prog_op[i] == OP_LW || prog_op[i] == OP_SW) begin
        prog_rs1[i] = 0;
        prog_imm[i] = 32'h400 + (32'(rand_below(256)) << 2);
      end
      mem0.imem_words[i] <= encode_inst(i);
    end
    for (int i = NUM_INSTS; i < IMEM_WORDS; i++) begin
      mem0.imem_words[i] <= {12'd0, 5'd0, 3'b000, 5'd0, `BLIMP_OP_IMM};
    end
  endtask

  task automatic seed_data();
    logic [31:0] w;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      w = lcg_next();
      mem0.dmem_words[i] <= w;
      model_data[i] = w;
    end
  endtask

  // ISA model step for the next instruction in program order
  task automatic check_retire();
    int          idx;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] value;
    logic        writes;
    idx    = retired;
    a      = model_regs[prog_rs1[idx]];
    b      = model_regs[prog_rs2[idx]];
    addr   = a + prog_imm[idx];
    writes = 1'b1;
    case (prog_op[idx])
      OP_ADD:  value = a + b;
      OP_SUB:  value = a - b;
      OP_AND:  value = a & b;
      OP_ADDI: value = a + prog_imm[idx];
      OP_LW:   value = model_data[addr[10:2]];
      default: begin
        model_data[addr[10:2]] = b;
        value  = 32'd0;
        writes = 1'b0;
      end
    endcase
    compare("trace_pc", trace_pc, `BLIMP_RESET_PC + (32'(idx) << 2));
    compare("trace_waddr", 32'(trace_waddr), writes ? 32'(prog_rd[idx]) : 32'd0);
    compare("trace_wdata", trace_wdata, value);
    compare("trace_wen", 32'(trace_wen), 32'(writes && prog_rd[idx] != 0));
    if (writes && prog_rd[idx] != 0) begin
      model_regs[prog_rd[idx]] = value;
    end
  endtask

  // ---------------------------------------------------------------------
  // Clock, wait states, timeout
  // ---------------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // 0 to 2 wait states, fresh each cycle
  always @(negedge clk) begin
    imem_wait = 2'(rand_below(3));
    dmem_wait = 2'(rand_below(3));
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Test FAILED");
      $fatal(1, "timeout after %0d cycles, %0d of %0d instructions retired",
             cycle_count, retired, NUM_INSTS);
    end
  end

  // ---------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------

  initial begin
    rst_n       = 1'b0;
    imem_wait   = 2'd0;
    dmem_wait   = 2'd0;
    rand_state  = 32'h4724;
    retired     = 0;
    cycle_count = 0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'd0;
    end
    build_program();
    seed_data();

    repeat (10) @(negedge clk);
    // Both buses and the trace quiet in reset
    compare("imem_psel", 32'(imem_psel), 32'd0);
    compare("dmem_psel", 32'(dmem_psel), 32'd0);
    compare("trace_val", 32'(trace_val), 32'd0);
    rst_n = 1'b1;

    while (!imem_psel) begin
      @(negedge clk);
    end
    compare("imem_paddr", imem_paddr, `BLIMP_RESET_PC);

    // One trace pulse per retire, sampled mid-cycle
    while (retired < NUM_INSTS) begin
      if (trace_val) begin
        check_retire();
        retired++;
      end
      @(negedge clk);
    end

    for (int i = 0; i < DMEM_WORDS; i++) begin
      compare($sformatf("dmem_words[%0d]", i), mem0.dmem_words[i], model_data[i]);
    end
    $display("Test OK");
    $finish;
  end

endmodule

//--- tb.f
+incdir+source
source/blimp_pkg.sv
source/blimp_ifs.sv
source/fetch_unit.sv
source/exec_unit.sv
source/mem_wb_unit.sv
source/blimp_core.sv
testbench/tb_mem_model.sv
testbench/tb_blimp.sv

//--- Makefile
# Verilator build and run for the blimp core testbench

VERILATOR ?= verilator
TOP       ?= tb_blimp
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
